// ==== logic/alu_pkg.sv ====
// Integer ALU execute unit shared definitions
// Data widths, uop encoding and the stage payload structs
// used on the dispatch and writeback sides of the pipeline

package alu_pkg;

  // --------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------

  // Data path width
  localparam int xlen          = 32;
  // Reorder buffer sequence number
  localparam int seq_num_bits  = 5;
  // Architectural register index
  localparam int reg_addr_bits = 5;
  // Micro-op code field
  localparam int uop_bits      = 4;
  // Shift amount taken from op2
  localparam int shamt_bits    = 5;

  // --------------------------------------------------------------------
  // Micro-op encoding
  // --------------------------------------------------------------------

  // Register-register and immediate forms share one code
  typedef enum logic [uop_bits-1:0] {
    uop_add  = 4'd0,
    uop_sub  = 4'd1,
    uop_and  = 4'd2,
    uop_or   = 4'd3,
    uop_xor  = 4'd4,
    uop_slt  = 4'd5,
    uop_sltu = 4'd6,
    uop_sll  = 4'd7,
    uop_srl  = 4'd8,
    uop_sra  = 4'd9,
    uop_lui  = 4'd10
  } alu_uop_e;

  // --------------------------------------------------------------------
  // Stage payloads
  // --------------------------------------------------------------------

  // Dispatch to execute
  typedef struct packed {
    logic [xlen-1:0]          pc;
    logic [seq_num_bits-1:0]  seq_num;
    logic [xlen-1:0]          op1;
    logic [xlen-1:0]          op2;
    logic [reg_addr_bits-1:0] waddr;
    alu_uop_e                 uop;
  } dispatch_msg_t;

  // Execute to writeback
  typedef struct packed {
    logic [xlen-1:0]          pc;
    logic [seq_num_bits-1:0]  seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [xlen-1:0]          wdata;
    logic                     wen;
  } writeback_msg_t;

endpackage

// ==== logic/alu_stage_reg.sv ====
// One-entry pipeline register on a val/rdy stream
// Holds a single payload of any packed type and passes it on
// the cycle after it is accepted, at one item per cycle

`timescale 1ns/1ps

module alu_stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,

  // Upstream side
  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_msg,

  // Downstream side
  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_msg
);

  // --------------------------------------------------------------------
  // State
  // --------------------------------------------------------------------

  // Entry occupied
  logic     full;
  // Held payload
  payload_t msg_q;
  // Input transfer this cycle
  logic     load;
  // Output transfer this cycle
  logic     drain;

  // --------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------

  assign drain  = full && out_rdy;
  // Space now, or the current item leaves on this edge
  assign in_rdy = !full || out_rdy;
  assign load   = in_val && in_rdy;

  // --------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------

  // Load wins over drain when both happen together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (drain) begin
      full <= 1'b0;
    end
  end

  // Payload only moves on an accepted input
  always_ff @(posedge clk) begin
    if (load) begin
      msg_q <= in_msg;
    end
  end

  assign out_val = full;
  assign out_msg = msg_q;

endmodule

// ==== logic/alu_compute.sv ====
// Combinational integer ALU
// Turns a dispatch payload into a writeback payload in zero cycles
// and suppresses register writes to x0

`timescale 1ns/1ps

module alu_compute (
  input  alu_pkg::dispatch_msg_t  d_msg,
  output alu_pkg::writeback_msg_t w_msg
);

  import alu_pkg::*;

  // --------------------------------------------------------------------
  // Operand views
  // --------------------------------------------------------------------

  logic [xlen-1:0]       op1;
  logic [xlen-1:0]       op2;
  logic [shamt_bits-1:0] shamt;
  logic                  lt_signed;
  logic                  lt_unsigned;
  logic [xlen-1:0]       sum;
  logic [xlen-1:0]       diff;
  logic [xlen-1:0]       sra_val;
  logic [xlen-1:0]       result;

  assign op1 = d_msg.op1;
  assign op2 = d_msg.op2;

  // Only the low bits of op2 count for shifts
  assign shamt = op2[shamt_bits-1:0];

  // Compares for slt and sltu
  assign lt_signed   = $signed(op1) < $signed(op2);
  assign lt_unsigned = op1 < op2;

  // Adder and subtractor wrap modulo 2^xlen
  assign sum  = op1 + op2;
  assign diff = op1 - op2;

  // Arithmetic right shift keeps the sign bit
  assign sra_val = $signed(op1) >>> shamt;

  // --------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------

  always_comb begin
    case (d_msg.uop)
      uop_add: begin
        result = sum;
      end
      uop_sub: begin
        result = diff;
      end
      uop_and: begin
        result = op1 & op2;
      end
      uop_or: begin
        result = op1 | op2;
      end
      uop_xor: begin
        result = op1 ^ op2;
      end
      // Set-less-than gives 1 or 0
      uop_slt: begin
        result = {{(xlen-1){1'b0}}, lt_signed};
      end
      uop_sltu: begin
        result = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      uop_sll: begin
        result = op1 << shamt;
      end
      uop_srl: begin
        result = op1 >> shamt;
      end
      uop_sra: begin
        result = sra_val;
      end
      // Upper immediate arrives already shifted in op2
      uop_lui: begin
        result = op2;
      end
      // Unused codes
      default: begin
        result = '0;
      end
    endcase
  end

  // --------------------------------------------------------------------
  // Writeback payload
  // --------------------------------------------------------------------

  // Tag fields pass straight through
  assign w_msg.pc      = d_msg.pc;
  assign w_msg.seq_num = d_msg.seq_num;
  assign w_msg.waddr   = d_msg.waddr;
  assign w_msg.wdata   = result;
  // No write to x0
  assign w_msg.wen     = (d_msg.waddr != '0);

endmodule

// ==== logic/alu_unit.sv ====
// Integer ALU execute unit
// Input stage register, combinational ALU and output stage register
// between the dispatch and writeback val/rdy streams

`timescale 1ns/1ps

module alu_unit (
  input  logic                              clk,
  input  logic                              rst_n,

  // Dispatch stream
  input  logic                              d_val,
  output logic                              d_rdy,
  input  logic [alu_pkg::xlen-1:0]          d_pc,
  input  logic [alu_pkg::seq_num_bits-1:0]  d_seq_num,
  input  logic [alu_pkg::xlen-1:0]          d_op1,
  input  logic [alu_pkg::xlen-1:0]          d_op2,
  input  logic [alu_pkg::reg_addr_bits-1:0] d_waddr,
  input  alu_pkg::alu_uop_e                 d_uop,

  // Writeback stream
  output logic                              w_val,
  input  logic                              w_rdy,
  output logic [alu_pkg::xlen-1:0]          w_pc,
  output logic [alu_pkg::seq_num_bits-1:0]  w_seq_num,
  output logic [alu_pkg::reg_addr_bits-1:0] w_waddr,
  output logic [alu_pkg::xlen-1:0]          w_wdata,
  output logic                              w_wen
);

  import alu_pkg::*;

  // --------------------------------------------------------------------
  // Internal stream wires
  // --------------------------------------------------------------------

  dispatch_msg_t  d_msg;
  dispatch_msg_t  x_msg;
  writeback_msg_t x_result;
  writeback_msg_t w_msg;
  // Input register to output register handshake
  logic           x_val;
  logic           x_rdy;

  // Pack loose dispatch ports
  assign d_msg.pc      = d_pc;
  assign d_msg.seq_num = d_seq_num;
  assign d_msg.op1     = d_op1;
  assign d_msg.op2     = d_op2;
  assign d_msg.waddr   = d_waddr;
  assign d_msg.uop     = d_uop;

  // --------------------------------------------------------------------
  // Pipeline
  // --------------------------------------------------------------------

  // Stage 1 holds the raw micro-op
  alu_stage_reg #(
    .payload_t (dispatch_msg_t)
  ) u_in_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (d_val),
    .in_rdy  (d_rdy),
    .in_msg  (d_msg),
    .out_val (x_val),
    .out_rdy (x_rdy),
    .out_msg (x_msg)
  );

  alu_compute u_compute (
    .d_msg (x_msg),
    .w_msg (x_result)
  );

  // Stage 2 holds results against writeback stalls
  alu_stage_reg #(
    .payload_t (writeback_msg_t)
  ) u_out_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (x_val),
    .in_rdy  (x_rdy),
    .in_msg  (x_result),
    .out_val (w_val),
    .out_rdy (w_rdy),
    .out_msg (w_msg)
  );

  // Unpack onto writeback ports
  assign w_pc      = w_msg.pc;
  assign w_seq_num = w_msg.seq_num;
  assign w_waddr   = w_msg.waddr;
  assign w_wdata   = w_msg.wdata;
  assign w_wen     = w_msg.wen;

endmodule

// ==== verif/alu_unit_assertions.sv ====
// Bound checks on the ALU execute unit
// Writeback handshake stability and stream state right after reset

`timescale 1ns/1ps

module alu_unit_assertions (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              d_rdy,
  input logic                              w_val,
  input logic                              w_rdy,
  input logic [alu_pkg::xlen-1:0]          w_pc,
  input logic [alu_pkg::seq_num_bits-1:0]  w_seq_num,
  input logic [alu_pkg::reg_addr_bits-1:0] w_waddr,
  input logic [alu_pkg::xlen-1:0]          w_wdata,
  input logic                              w_wen
);

  // Count of failed checks
  int fail_count;

  // --------------------------------------------------------------------
  // Writeback stall
  // --------------------------------------------------------------------

  // Stalled output keeps valid and every payload field
  w_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n)
      (w_val && !w_rdy) |=> (w_val && $stable(w_pc) && $stable(w_seq_num)
        && $stable(w_waddr) && $stable(w_wdata) && $stable(w_wen))
  ) else begin
    fail_count++;
    $error("w_val or the W payload changed while w_rdy was low");
  end

  // --------------------------------------------------------------------
  // Reset state
  // --------------------------------------------------------------------

  // Both stage registers empty on first edge out of reset
  w_val_reset_a: assert property (@(posedge clk) $rose(rst_n) |-> !w_val)
  else begin
    fail_count++;
    $error("w_val was high in the first cycle after reset");
  end

  d_rdy_reset_a: assert property (@(posedge clk) $rose(rst_n) |-> d_rdy)
  else begin
    fail_count++;
    $error("d_rdy was low in the first cycle after reset");
  end

endmodule

// ==== verif/alu_unit_checker.sv ====
// Scoreboard for the ALU execute unit
// Queues the expected writeback of each dispatched micro-op and
// compares it with each transfer on the writeback stream

`timescale 1ns/1ps

module alu_unit_checker (
  input  logic                              clk,
  input  logic                              rst_n,
  // Dispatch stream plus the expected result of the micro-op on it
  input  logic                              d_val,
  input  logic                              d_rdy,
  input  logic [alu_pkg::xlen-1:0]          d_pc,
  input  logic [alu_pkg::seq_num_bits-1:0]  d_seq_num,
  input  logic [alu_pkg::xlen-1:0]          d_op1,
  input  logic [alu_pkg::xlen-1:0]          d_op2,
  input  logic [alu_pkg::reg_addr_bits-1:0] d_waddr,
  input  alu_pkg::alu_uop_e                 d_uop,
  input  logic [alu_pkg::xlen-1:0]          d_exp_wdata,
  // Writeback stream
  input  logic                              w_val,
  input  logic                              w_rdy,
  input  logic [alu_pkg::xlen-1:0]          w_pc,
  input  logic [alu_pkg::seq_num_bits-1:0]  w_seq_num,
  input  logic [alu_pkg::reg_addr_bits-1:0] w_waddr,
  input  logic [alu_pkg::xlen-1:0]          w_wdata,
  input  logic                              w_wen,
  output int                                error_count,
  output int                                recv_count
);

  import alu_pkg::*;

  // Expected writeback and the micro-op that produced it
  typedef struct packed {
    writeback_msg_t  wb;
    alu_uop_e        uop;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
  } exp_entry_t;

  // Micro-ops in flight with the oldest at the front
  exp_entry_t exp_q[$];
  exp_entry_t exp_ent;
  int         errors_before;

  task automatic check_field(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s expected 0x%08h actual 0x%08h",
               $time, name, expected, actual);
    end
  endtask

  // --------------------------------------------------------------------
  // Stream monitor
  // --------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      exp_q.delete();
      error_count = 0;
      recv_count  = 0;
    end else begin
      // Writeback is handled before dispatch as a micro-op needs two edges to cross
      if (w_val && w_rdy) begin
        recv_count++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Writeback at %0t arrived with no dispatched micro-op left", $time);
        end else begin
          exp_ent       = exp_q.pop_front();
          errors_before = error_count;
          check_field("w_pc", exp_ent.wb.pc, w_pc);
          check_field("w_seq_num", xlen'(exp_ent.wb.seq_num), xlen'(w_seq_num));
          check_field("w_waddr", xlen'(exp_ent.wb.waddr), xlen'(w_waddr));
          check_field("w_wdata", exp_ent.wb.wdata, w_wdata);
          check_field("w_wen", xlen'(exp_ent.wb.wen), xlen'(w_wen));
          // Name the micro-op behind a mismatch
          if (error_count != errors_before) begin
            $display("Mismatch came from uop 0x%0h with op1 0x%08h op2 0x%08h",
                     exp_ent.uop, exp_ent.op1, exp_ent.op2);
          end
        end
      end
      if (d_val && d_rdy) begin
        exp_ent.wb.pc      = d_pc;
        exp_ent.wb.seq_num = d_seq_num;
        exp_ent.wb.waddr   = d_waddr;
        exp_ent.wb.wdata   = d_exp_wdata;
        // x0 is never written
        exp_ent.wb.wen     = (d_waddr != '0);
        exp_ent.uop        = d_uop;
        exp_ent.op1        = d_op1;
        exp_ent.op2        = d_op2;
        exp_q.push_back(exp_ent);
      end
    end
  end

endmodule

// ==== verif/alu_unit_tb.sv ====
// Testbench for the integer ALU execute unit
// Reads micro-ops from the case file, drives dispatch with random gaps
// under random writeback back-pressure and reports the outcome

`timescale 1ns/1ps

module alu_unit_tb;

  import alu_pkg::*;

  localparam string       cases_path     = "verif/alu_unit_cases.txt";
  localparam int          timeout_cycles = 200;
  // Last cases go back to back with writeback always ready
  localparam int          burst_len      = 8;
  localparam logic [31:0] lfsr_seed      = 32'ha9bc_abc4;

  // One line of the case file
  typedef struct packed {
    logic [31:0] uop;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] waddr;
    logic [31:0] pc;
    logic [31:0] seq;
    logic [31:0] wdata;
  } case_t;

  logic                     clk;
  logic                     rst_n;
  logic                     d_val;
  logic                     d_rdy;
  logic [xlen-1:0]          d_pc;
  logic [seq_num_bits-1:0]  d_seq_num;
  logic [xlen-1:0]          d_op1;
  logic [xlen-1:0]          d_op2;
  logic [reg_addr_bits-1:0] d_waddr;
  alu_uop_e                 d_uop;
  logic [xlen-1:0]          d_exp_wdata;
  logic                     w_val;
  logic                     w_rdy;
  logic [xlen-1:0]          w_pc;
  logic [seq_num_bits-1:0]  w_seq_num;
  logic [reg_addr_bits-1:0] w_waddr;
  logic [xlen-1:0]          w_wdata;
  logic                     w_wen;

  int          chk_errors;
  int          recv_count;
  int          tb_errors;
  int          timeouts;
  bit          aborted;
  bit          burst_mode;
  logic [31:0] lfsr;
  case_t       cases[$];

  // --------------------------------------------------------------------
  // Clock, DUT, checker and bound assertions
  // --------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  alu_unit i_dut (
    .clk (clk), .rst_n (rst_n),
    .d_val (d_val), .d_rdy (d_rdy), .d_pc (d_pc), .d_seq_num (d_seq_num),
    .d_op1 (d_op1), .d_op2 (d_op2), .d_waddr (d_waddr), .d_uop (d_uop),
    .w_val (w_val), .w_rdy (w_rdy), .w_pc (w_pc), .w_seq_num (w_seq_num),
    .w_waddr (w_waddr), .w_wdata (w_wdata), .w_wen (w_wen)
  );

  alu_unit_checker u_checker (
    .clk (clk), .rst_n (rst_n),
    .d_val (d_val), .d_rdy (d_rdy), .d_pc (d_pc), .d_seq_num (d_seq_num),
    .d_op1 (d_op1), .d_op2 (d_op2), .d_waddr (d_waddr), .d_uop (d_uop),
    .d_exp_wdata (d_exp_wdata),
    .w_val (w_val), .w_rdy (w_rdy), .w_pc (w_pc), .w_seq_num (w_seq_num),
    .w_waddr (w_waddr), .w_wdata (w_wdata), .w_wen (w_wen),
    .error_count (chk_errors), .recv_count (recv_count)
  );

  bind alu_unit alu_unit_assertions u_assertions (
    .clk (clk), .rst_n (rst_n), .d_rdy (d_rdy), .w_val (w_val), .w_rdy (w_rdy),
    .w_pc (w_pc), .w_seq_num (w_seq_num), .w_waddr (w_waddr),
    .w_wdata (w_wdata), .w_wen (w_wen)
  );

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic int unsigned take_bits(input int n);
    int unsigned value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  // Advance to the next falling edge, then update writeback ready
  task automatic next_cycle();
    @(negedge clk);
    if (burst_mode) begin
      w_rdy = 1'b1;
    end else begin
      w_rdy = (take_bits(2) != 0);
    end
  endtask

  // Comment lines fail the scan and drop out
  task automatic load_cases();
    int    fd;
    string line;
    case_t c;
    fd = $fopen(cases_path, "r");
    if (fd == 0) begin
      tb_errors++;
      $display("Could not open the case file %s", cases_path);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%h %h %h %h %h %h %h",
                  c.uop, c.op1, c.op2, c.waddr, c.pc, c.seq, c.wdata) == 7) begin
        cases.push_back(c);
      end
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      tb_errors++;
      $display("The case file holds no micro-ops");
    end
  endtask

  // Hold one micro-op on D until a rising edge sees d_rdy
  task automatic send_case(input case_t c);
    int waited;
    d_val       = 1'b1;
    d_uop       = alu_uop_e'(c.uop[uop_bits-1:0]);
    d_op1       = c.op1;
    d_op2       = c.op2;
    d_waddr     = c.waddr[reg_addr_bits-1:0];
    d_pc        = c.pc;
    d_seq_num   = c.seq[seq_num_bits-1:0];
    d_exp_wdata = c.wdata;
    waited      = 0;
    forever begin
      @(posedge clk);
      if (burst_mode && !d_rdy) begin
        tb_errors++;
        $display("Error at %0t: d_rdy expected 1 actual 0 in full-rate burst", $time);
      end
      if (d_rdy) begin
        break;
      end
      waited++;
      if (waited >= timeout_cycles) begin
        timeouts++;
        aborted = 1'b1;
        $display("Dispatch timed out, d_rdy stayed low for %0d cycles", waited);
        break;
      end
      next_cycle();
    end
    next_cycle();
  endtask

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------

  initial begin
    int gap;
    int waited;
    rst_n       = 1'b0;
    d_val       = 1'b0;
    d_pc        = '0;
    d_seq_num   = '0;
    d_op1       = '0;
    d_op2       = '0;
    d_waddr     = '0;
    d_uop       = uop_add;
    d_exp_wdata = '0;
    w_rdy       = 1'b0;
    lfsr        = lfsr_seed;
    tb_errors   = 0;
    timeouts    = 0;
    aborted     = 1'b0;
    burst_mode  = 1'b0;
    load_cases();

    // Reset for 10 cycles and release on a falling edge
    repeat (10) @(posedge clk);
    next_cycle();
    rst_n = 1'b1;

    for (int i = 0; i < cases.size() && !aborted; i++) begin
      if (i >= cases.size() - burst_len) begin
        burst_mode = 1'b1;
        w_rdy      = 1'b1;
      end
      if (!burst_mode) begin
        gap   = take_bits(2);
        d_val = 1'b0;
        repeat (gap) next_cycle();
      end
      send_case(cases[i]);
    end
    d_val = 1'b0;

    // Drain the pipeline
    waited = 0;
    while (recv_count < cases.size() && waited < timeout_cycles && !aborted) begin
      next_cycle();
      waited++;
    end
    if (!aborted && recv_count < cases.size()) begin
      timeouts++;
      $display("Timed out waiting for writebacks, %0d of %0d received",
               recv_count, cases.size());
    end
    // Idle cycles expose any extra writeback
    repeat (4) next_cycle();

    $display("Checker errors %0d, testbench errors %0d, assertion failures %0d, timeouts %0d",
             chk_errors, tb_errors, i_dut.u_assertions.fail_count, timeouts);
    if (chk_errors + tb_errors + i_dut.u_assertions.fail_count + timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== alu_unit.f ====
logic/alu_pkg.sv
logic/alu_stage_reg.sv
logic/alu_compute.sv
logic/alu_unit.sv
verif/alu_unit_assertions.sv
verif/alu_unit_checker.sv
verif/alu_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ALU execute unit testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="${build_dir}/sim.log"

mkdir -p "${build_dir}" || exit 1

# Compile the RTL and testbench from the file list
verilator --binary --timing --assert -j 0 \
  --top-module alu_unit_tb \
  -f alu_unit.f \
  --Mdir "${build_dir}" -o alu_unit_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Run, keep going past assertion errors so the testbench can report
"./${build_dir}/alu_unit_sim" +verilator+error+limit+1000 > "${log_file}" 2>&1
run_status=$?
cat "${log_file}"
if [ ${run_status} -ne 0 ]; then
  echo "Simulator exited with status ${run_status}"
  exit 1
fi

if grep -q "Simulation failed" "${log_file}"; then
  exit 1
fi
exit 0

// ==== verif/alu_unit_cases.txt ====
# Columns, all hex: uop op1 op2 waddr pc seq_num expected_wdata
# uop codes: 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sltu 7 sll 8 srl 9 sra a lui
0 00000005 00000007 01 00001000 00 0000000c
0 ffffffff 00000001 02 00001004 01 00000000
1 00000003 00000005 03 00001008 02 fffffffe
1 80000000 00000001 04 0000100c 03 7fffffff
2 f0f0f0f0 ff00ff00 05 00001010 04 f000f000
3 f0f0f0f0 0f0f0000 06 00001014 05 fffff0f0
4 aaaaaaaa ffff0000 07 00001018 06 5555aaaa
5 ffffffff 00000001 08 0000101c 07 00000001
6 ffffffff 00000001 09 00001020 08 00000000
5 00000001 ffffffff 0a 00001024 09 00000000
6 00000001 ffffffff 0b 00001028 0a 00000001
5 80000000 7fffffff 0c 0000102c 0b 00000001
7 00000001 0000001f 0d 00001030 0c 80000000
7 00000003 00000024 0e 00001034 0d 00000030
8 80000000 0000001f 0f 00001038 0e 00000001
8 f0000000 00000104 10 0000103c 0f 0f000000
9 80000000 0000001f 11 00001040 10 ffffffff
9 f0000000 00000024 12 00001044 11 ff000000
9 7ffffff0 00000004 13 00001048 12 07ffffff
a 00000000 12345000 14 0000104c 13 12345000
0 00000010 00000020 00 00001050 14 00000030
a ffffffff fffff000 00 00001054 15 fffff000
4 12345678 12345678 15 00001058 16 00000000
1 00000000 00000001 16 0000105c 17 ffffffff
0 7fffffff 00000001 17 00001060 18 80000000
2 12345678 0000ffff 18 00001064 19 00005678
3 00000000 00000000 19 00001068 1a 00000000
6 00000000 00000000 1a 0000106c 1b 00000000
5 fffffffe ffffffff 1b 00001070 1c 00000001
7 ffffffff 00000020 1c 00001074 1d ffffffff
8 12345678 00000008 1d 00001078 1e 00123456
9 87654321 00000008 1f 0000107c 1f ff876543
